// File: mmio_pkg.sv
`default_nettype none

package mmio_pkg;

    // CPU side words
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Address map in byte addresses
    localparam addr_t RAM_BASE           = 32'h0000_0000;
    localparam addr_t RAM_SPAN_BYTES     = 32'h0000_1000;
    localparam addr_t KEYPAD_ADDR        = 32'h0000_2000;
    localparam addr_t DISPLAY_BASE       = 32'h0000_3000;
    localparam addr_t DISPLAY_SPAN_BYTES = 32'h0000_1000;

    // Read value for holes in the map
    localparam word_t UNMAPPED_WORD = 32'hDEAD_BEEF;

    // Keypad codes
    typedef logic [4:0] key_button_t;
    typedef logic [1:0] key_app_t;

    // Keypad word layout with all other bits reading zero
    localparam int KEY_VALID_BIT  = 31;
    localparam int KEY_APP_LSB    = 5;
    localparam int KEY_BUTTON_LSB = 0;

    // Decoded destination of one access
    typedef enum logic [1:0] {
        RAM,
        KEYPAD,
        DISPLAY,
        NONE
    } target_t;

    // Control FSM
    typedef enum logic [2:0] {
        IDLE,
        RAM_WAIT,
        KEY_WAIT,
        DISP_WAIT,
        RESPOND
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: wb_pkg.sv
`default_nettype none

package wb_pkg;

    // Bus widths
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;

    // Bus manager FSM
    // ACTIVE covers the whole cycle from strobe to ack
    typedef enum logic [1:0] {
        IDLE,
        ACTIVE,
        DONE
    } wbm_state_t;

endpackage

`default_nettype wire

// File: wb_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

interface wb_bus_if
    import wb_pkg::*;
();

    wb_addr_t adr;
    wb_data_t dat_w;
    wb_data_t dat_r;
    wb_sel_t  sel;
    logic     we;
    logic     stb;
    logic     cyc;
    logic     ack;

    // Request side of the bus
    modport manager (
        output adr,
        output dat_w,
        output sel,
        output we,
        output stb,
        output cyc,
        input  dat_r,
        input  ack
    );

    // Word RAM side
    modport slave (
        input  adr,
        input  dat_w,
        input  sel,
        input  we,
        input  stb,
        input  cyc,
        output dat_r,
        output ack
    );

endinterface

`default_nettype wire

// File: mmio_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mmio_ctrl
    import mmio_pkg::*;
#(
    parameter int RAM_WORDS = 1024
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  fetch_i,
    input  wire addr_t pc_i,
    input  wire logic  mem_read_i,
    input  wire logic  mem_write_i,
    input  wire addr_t address_i,
    input  wire word_t store_data_i,
    input  wire word_t ram_rdata_i,
    input  wire logic  ram_done_i,
    input  wire word_t key_word_i,
    input  wire logic  display_ack_i,
    output logic       ram_start_o,
    output logic       ram_write_o,
    output addr_t      ram_addr_o,
    output word_t      ram_wdata_o,
    output logic       key_read_o,
    output logic       display_wen_o,
    output logic       d_ack_o,
    output logic       i_ack_o,
    output word_t      memload_o,
    output word_t      instruction_o
);

    // RAM window shrinks with a smaller array
    localparam addr_t RAM_BYTES = (RAM_WORDS * 4 < RAM_SPAN_BYTES) ?
                                  addr_t'(RAM_WORDS * 4) : RAM_SPAN_BYTES;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        rest_q;
    logic        is_data_q;
    logic        write_q;
    word_t       resp_q;
    logic        data_req;
    logic        take_req;
    addr_t       served_addr;
    target_t     target;

    function automatic target_t decode_target(input addr_t addr);
        target_t tgt;
        if (addr >= RAM_BASE && addr < RAM_BASE + RAM_BYTES)
            tgt = RAM;
        else if (addr == KEYPAD_ADDR)
            tgt = KEYPAD;
        else if (addr >= DISPLAY_BASE && addr < DISPLAY_BASE + DISPLAY_SPAN_BYTES)
            tgt = DISPLAY;
        else
            tgt = NONE;
        return tgt;
    endfunction

    // Data beats fetch when both are pending
    assign data_req    = mem_read_i | mem_write_i;
    assign served_addr = data_req ? address_i : pc_i;
    assign target      = decode_target(served_addr);

    // One idle cycle after each response lets the CPU drop its request
    assign take_req = (state_q == IDLE) && !rest_q && (data_req || fetch_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (take_req) begin
                    case (target)
                        RAM:     state_d = RAM_WAIT;
                        KEYPAD:  state_d = KEY_WAIT;
                        DISPLAY: state_d = mem_write_i ? DISP_WAIT : RESPOND;
                        default: state_d = RESPOND;
                    endcase
                end
            end
            RAM_WAIT:  if (ram_done_i) state_d = RESPOND;
            KEY_WAIT:  state_d = RESPOND;
            DISP_WAIT: if (display_ack_i) state_d = RESPOND;
            RESPOND:   state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q   <= IDLE;
            rest_q    <= 1'b0;
            is_data_q <= 1'b0;
            write_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            rest_q  <= (state_q == RESPOND);
            if (take_req) begin
                is_data_q <= data_req;
                write_q   <= mem_write_i;
            end
        end
    end

    // Single response word for both acknowledges
    always_ff @(posedge clk) begin
        if (take_req && (target == NONE || target == DISPLAY))
            resp_q <= UNMAPPED_WORD;
        else if (state_q == RAM_WAIT && ram_done_i)
            resp_q <= ram_rdata_i;
        else if (state_q == KEY_WAIT)
            resp_q <= key_word_i;
    end

    // The manager latches these on start
    assign ram_start_o = take_req && (target == RAM);
    assign ram_write_o = mem_write_i;
    assign ram_addr_o  = served_addr;
    assign ram_wdata_o = store_data_i;

    // Keypad write is acknowledged but never clears valid
    assign key_read_o    = (state_q == KEY_WAIT) && !write_q;
    assign display_wen_o = (state_q == DISP_WAIT);

    assign d_ack_o       = (state_q == RESPOND) && is_data_q;
    assign i_ack_o       = (state_q == RESPOND) && !is_data_q;
    assign memload_o     = resp_q;
    assign instruction_o = resp_q;

    a_one_ack: assert property (@(posedge clk) disable iff (reset)
        (d_ack_o || i_ack_o) |=> !(d_ack_o || i_ack_o) ##1 !(d_ack_o || i_ack_o))
        else $error("Acknowledge repeated before the CPU could drop its request");

    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        ram_start_o |-> (state_q == IDLE) ##1 (state_q == RAM_WAIT))
        else $error("RAM start outside IDLE or without entering RAM_WAIT");

endmodule

`default_nettype wire

// File: wb_manager.sv
`timescale 1ns/100ps
`default_nettype none

module wb_manager
    import wb_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     start_i,
    input  wire logic     write_i,
    input  wire wb_addr_t addr_i,
    input  wire wb_data_t wdata_i,
    output wb_data_t      rdata_o,
    output logic          done_o,
    wb_bus_if.manager     bus
);

    // Only full-word accesses
    localparam wb_sel_t FULL_WORD = '1;

    wbm_state_t state_q;
    logic       stb_q;
    logic       we_q;
    wb_addr_t   adr_q;
    wb_data_t   wdata_q;
    wb_data_t   rdata_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= IDLE;
            stb_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= ACTIVE;
                        stb_q   <= 1'b1;
                    end
                end
                ACTIVE: begin
                    // Cycle ends on the slave ack
                    if (bus.ack) begin
                        state_q <= DONE;
                        stb_q   <= 1'b0;
                    end
                end
                DONE:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Request and read data
    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            adr_q   <= addr_i;
            wdata_q <= wdata_i;
            we_q    <= write_i;
        end
        if (state_q == ACTIVE && bus.ack && !we_q)
            rdata_q <= bus.dat_r;
    end

    assign bus.adr   = adr_q;
    assign bus.dat_w = wdata_q;
    assign bus.sel   = FULL_WORD;
    assign bus.we    = we_q;
    assign bus.stb   = stb_q;
    assign bus.cyc   = (state_q == ACTIVE);

    assign rdata_o = rdata_q;
    assign done_o  = (state_q == DONE);

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        bus.stb |-> bus.cyc)
        else $error("Strobe raised outside a bus cycle");

endmodule

`default_nettype wire

// File: sram_wb.sv
`timescale 1ns/100ps
`default_nettype none

module sram_wb
    import wb_pkg::*;
#(
    parameter int RAM_WORDS = 1024
) (
    input  wire logic clk,
    input  wire logic reset,
    wb_bus_if.slave   bus
);

    localparam int AW = $clog2(RAM_WORDS);

    wb_data_t      mem [RAM_WORDS];
    logic [AW-1:0] word_idx;
    logic          hit;

    // Byte address to word index
    assign word_idx = bus.adr[2 +: AW];

    // Ignore the strobe that is still up during the ack cycle
    assign hit = bus.stb && bus.cyc && !bus.ack;

    always_ff @(posedge clk) begin
        if (hit) begin
            if (bus.we && (&bus.sel))
                mem[word_idx] <= bus.dat_w;
            bus.dat_r <= mem[word_idx];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            bus.ack <= 1'b0;
        else
            bus.ack <= hit;
    end

    a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
        bus.ack |=> !bus.ack)
        else $error("RAM ack held for more than one cycle");

endmodule

`default_nettype wire

// File: keypad_reg.sv
`timescale 1ns/100ps
`default_nettype none

module keypad_reg
    import mmio_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire key_button_t button_i,
    input  wire key_app_t    app_i,
    input  wire logic        rising_i,
    input  wire logic        read_i,
    output word_t            key_word_o
);

    key_button_t button_q;
    key_app_t    app_q;
    logic        valid_q;

    // Codes survive a read
    always_ff @(posedge clk) begin
        if (rising_i) begin
            button_q <= button_i;
            app_q    <= app_i;
        end
    end

    // A new key wins over a read in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            valid_q <= 1'b0;
        else if (rising_i)
            valid_q <= 1'b1;
        else if (read_i)
            valid_q <= 1'b0;
    end

    always_comb begin
        key_word_o = '0;
        key_word_o[KEY_VALID_BIT] = valid_q;
        key_word_o[KEY_APP_LSB +: $bits(key_app_t)] = app_q;
        key_word_o[KEY_BUTTON_LSB +: $bits(key_button_t)] = button_q;
    end

endmodule

`default_nettype wire

// File: mmio_top.sv
`timescale 1ns/100ps
`default_nettype none

module mmio_top
    import mmio_pkg::*;
#(
    parameter int RAM_WORDS = 1024
) (
    input  wire logic        clk,
    input  wire logic        reset,

    // CPU port
    input  wire logic        fetch_i,
    input  wire addr_t       pc_i,
    input  wire logic        mem_read_i,
    input  wire logic        mem_write_i,
    input  wire addr_t       address_i,
    input  wire word_t       store_data_i,

    // Keypad
    input  wire key_button_t button_i,
    input  wire key_app_t    app_i,
    input  wire logic        rising_i,

    input  wire logic        display_ack_i,
    output logic             d_ack_o,
    output logic             i_ack_o,
    output word_t            memload_o,
    output word_t            instruction_o,

    // Display port
    output addr_t            display_address_o,
    output word_t            display_data_o,
    output logic             display_wen_o
);

    logic  ram_start;
    logic  ram_write;
    addr_t ram_addr;
    word_t ram_wdata;
    word_t ram_rdata;
    logic  ram_done;
    logic  key_read;
    word_t key_word;

    wb_bus_if i_ram_bus ();

    mmio_ctrl #(
        .RAM_WORDS (RAM_WORDS)
    ) i_mmio_ctrl (
        .clk           (clk),
        .reset         (reset),
        .fetch_i       (fetch_i),
        .pc_i          (pc_i),
        .mem_read_i    (mem_read_i),
        .mem_write_i   (mem_write_i),
        .address_i     (address_i),
        .store_data_i  (store_data_i),
        .ram_rdata_i   (ram_rdata),
        .ram_done_i    (ram_done),
        .key_word_i    (key_word),
        .display_ack_i (display_ack_i),
        .ram_start_o   (ram_start),
        .ram_write_o   (ram_write),
        .ram_addr_o    (ram_addr),
        .ram_wdata_o   (ram_wdata),
        .key_read_o    (key_read),
        .display_wen_o (display_wen_o),
        .d_ack_o       (d_ack_o),
        .i_ack_o       (i_ack_o),
        .memload_o     (memload_o),
        .instruction_o (instruction_o)
    );

    wb_manager i_wb_manager (
        .clk     (clk),
        .reset   (reset),
        .start_i (ram_start),
        .write_i (ram_write),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata),
        .done_o  (ram_done),
        .bus     (i_ram_bus.manager)
    );

    sram_wb #(
        .RAM_WORDS (RAM_WORDS)
    ) i_sram_wb (
        .clk   (clk),
        .reset (reset),
        .bus   (i_ram_bus.slave)
    );

    keypad_reg i_keypad_reg (
        .clk        (clk),
        .reset      (reset),
        .button_i   (button_i),
        .app_i      (app_i),
        .rising_i   (rising_i),
        .read_i     (key_read),
        .key_word_o (key_word)
    );

    // Display sees the CPU data port directly and qualifies it by display_wen_o
    assign display_address_o = address_i;
    assign display_data_o    = store_data_i;

endmodule

`default_nettype wire

// File: tb_mmio.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mmio
    import mmio_pkg::*;
();

    localparam int RAM_WORDS   = 1024;
    localparam int NUM_WRITES  = 16;
    localparam int NUM_READS   = 16;
    localparam int NUM_FETCHES = 8;
    // About 60 accesses of at most 20 cycles each with margin
    localparam int CYCLE_LIMIT = 4000;

    logic        clk;
    logic        reset;
    logic        fetch_i;
    addr_t       pc_i;
    logic        mem_read_i;
    logic        mem_write_i;
    addr_t       address_i;
    word_t       store_data_i;
    key_button_t button_i;
    key_app_t    app_i;
    logic        rising_i;
    logic        display_ack_i;
    logic        d_ack_o;
    logic        i_ack_o;
    word_t       memload_o;
    word_t       instruction_o;
    addr_t       display_address_o;
    word_t       display_data_o;
    logic        display_wen_o;

    // Expected values and check enables set by the access tasks
    string  test_name = "startup";
    word_t  exp_load;
    word_t  exp_instr;
    logic   chk_load = 1'b0;
    logic   chk_instr = 1'b0;
    int     exp_dlat = 0;
    addr_t  exp_disp_addr;
    word_t  exp_disp_data;
    logic   disp_wait_chk = 1'b0;
    int     req_age;
    int     cycle_count = 0;
    integer seed = 32'he39f47a1;
    word_t  ref_mem [RAM_WORDS];
    addr_t  used_addr [$];

    mmio_top #(
        .RAM_WORDS (RAM_WORDS)
    ) i_mmio_top (
        .clk               (clk),
        .reset             (reset),
        .fetch_i           (fetch_i),
        .pc_i              (pc_i),
        .mem_read_i        (mem_read_i),
        .mem_write_i       (mem_write_i),
        .address_i         (address_i),
        .store_data_i      (store_data_i),
        .button_i          (button_i),
        .app_i             (app_i),
        .rising_i          (rising_i),
        .display_ack_i     (display_ack_i),
        .d_ack_o           (d_ack_o),
        .i_ack_o           (i_ack_o),
        .memload_o         (memload_o),
        .instruction_o     (instruction_o),
        .display_address_o (display_address_o),
        .display_data_o    (display_data_o),
        .display_wen_o     (display_wen_o)
    );

    always #4 clk = ~clk;

    // Cycles a CPU request has been sampled high
    always @(posedge clk or posedge reset) begin
        if (reset)
            req_age <= 0;
        else if (fetch_i || mem_read_i || mem_write_i)
            req_age <= req_age + 1;
        else
            req_age <= 0;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
            report_failure("run did not finish within the cycle limit");
    end

    task automatic report_failure(input string what);
        $display("Test %s: %s", test_name, what);
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic report_mismatch(input string what, input word_t expected, input word_t actual);
        $display("MISMATCH test %s, %s: expected %h, actual %h",
                 test_name, what, expected, actual);
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    endtask

    function automatic word_t key_word_expected(input logic valid, input key_app_t app,
                                                input key_button_t button);
        word_t w;
        w = '0;
        w[31] = valid;
        w[6:5] = app;
        w[4:0] = button;
        return w;
    endfunction

    function automatic addr_t random_ram_addr();
        word_t rnd;
        rnd = $random(seed);
        return addr_t'({rnd[9:0], 2'b00});
    endfunction

    a_no_stray_dack: assert property (@(posedge clk) disable iff (reset)
        d_ack_o |-> (mem_read_i || mem_write_i))
        else report_failure("d_ack_o pulsed with no data request pending");

    a_no_stray_iack: assert property (@(posedge clk) disable iff (reset)
        i_ack_o |-> fetch_i)
        else report_failure("i_ack_o pulsed with no fetch pending");

    a_data_first: assert property (@(posedge clk) disable iff (reset)
        i_ack_o |-> !(mem_read_i || mem_write_i))
        else report_failure("fetch acknowledged while a data request was pending");

    a_load: assert property (@(posedge clk) disable iff (reset)
        (d_ack_o && chk_load) |-> (memload_o == exp_load))
        else report_mismatch("memload_o", $sampled(exp_load), $sampled(memload_o));

    a_instr: assert property (@(posedge clk) disable iff (reset)
        (i_ack_o && chk_instr) |-> (instruction_o == exp_instr))
        else report_mismatch("instruction_o", $sampled(exp_instr), $sampled(instruction_o));

    a_latency: assert property (@(posedge clk) disable iff (reset)
        (d_ack_o && exp_dlat != 0) |-> (req_age == exp_dlat))
        else report_mismatch("ack latency", $sampled(exp_dlat), $sampled(req_age));

    a_disp_wen: assert property (@(posedge clk) disable iff (reset)
        disp_wait_chk |-> display_wen_o)
        else report_failure("display_wen_o low while the display write was pending");

    a_disp_addr: assert property (@(posedge clk) disable iff (reset)
        display_wen_o |-> (display_address_o == exp_disp_addr))
        else report_mismatch("display_address_o", $sampled(exp_disp_addr),
                             $sampled(display_address_o));

    a_disp_data: assert property (@(posedge clk) disable iff (reset)
        display_wen_o |-> (display_data_o == exp_disp_data))
        else report_mismatch("display_data_o", $sampled(exp_disp_data),
                             $sampled(display_data_o));

    a_disp_stall: assert property (@(posedge clk) disable iff (reset)
        (display_wen_o && !display_ack_i) |=> !d_ack_o)
        else report_failure("d_ack_o raised before the display acknowledged");

    a_disp_ack: assert property (@(posedge clk) disable iff (reset)
        (display_wen_o && display_ack_i) |=> d_ack_o)
        else report_failure("d_ack_o missing in the cycle after display_ack_i");

    // Drop the request after the ack edge, then leave the idle cycle
    task automatic end_access();
        @(negedge clk);
        fetch_i = 1'b0;
        mem_read_i = 1'b0;
        mem_write_i = 1'b0;
        chk_load = 1'b0;
        chk_instr = 1'b0;
        exp_dlat = 0;
        @(negedge clk);
    endtask

    task automatic wait_data_ack();
        @(negedge clk);
        while (!d_ack_o)
            @(negedge clk);
    endtask

    task automatic cpu_write(input addr_t addr, input word_t data, input int lat);
        exp_dlat = lat;
        address_i = addr;
        store_data_i = data;
        mem_write_i = 1'b1;
        wait_data_ack();
        if (addr < RAM_WORDS * 4)
            ref_mem[addr >> 2] = data;
        end_access();
    endtask

    task automatic cpu_read(input addr_t addr, input word_t expected, input int lat);
        exp_load = expected;
        chk_load = 1'b1;
        exp_dlat = lat;
        address_i = addr;
        mem_read_i = 1'b1;
        wait_data_ack();
        end_access();
    endtask

    task automatic cpu_fetch(input addr_t addr);
        exp_instr = ref_mem[addr >> 2];
        chk_instr = 1'b1;
        pc_i = addr;
        fetch_i = 1'b1;
        @(negedge clk);
        while (!i_ack_o)
            @(negedge clk);
        end_access();
    endtask

    task automatic cpu_read_and_fetch(input addr_t daddr, input addr_t iaddr);
        exp_load = ref_mem[daddr >> 2];
        exp_instr = ref_mem[iaddr >> 2];
        chk_load = 1'b1;
        chk_instr = 1'b1;
        address_i = daddr;
        pc_i = iaddr;
        mem_read_i = 1'b1;
        fetch_i = 1'b1;
        wait_data_ack();
        @(negedge clk);
        mem_read_i = 1'b0;
        chk_load = 1'b0;
        while (!i_ack_o)
            @(negedge clk);
        end_access();
    endtask

    task automatic key_press(input key_button_t button, input key_app_t app);
        button_i = button;
        app_i = app;
        rising_i = 1'b1;
        @(negedge clk);
        rising_i = 1'b0;
        @(negedge clk);
    endtask

    task automatic display_write(input addr_t addr, input word_t data, input int hold);
        exp_disp_addr = addr;
        exp_disp_data = data;
        address_i = addr;
        store_data_i = data;
        mem_write_i = 1'b1;
        @(negedge clk);
        disp_wait_chk = 1'b1;
        repeat (hold) @(negedge clk);
        display_ack_i = 1'b1;
        @(negedge clk);
        display_ack_i = 1'b0;
        disp_wait_chk = 1'b0;
        while (!d_ack_o)
            @(negedge clk);
        end_access();
    endtask

    initial begin
        word_t       rnd;
        addr_t       addr;
        key_button_t button;
        key_app_t    app;
        int          pick;
        clk = 1'b0;
        reset = 1'b1;
        fetch_i = 1'b0;
        pc_i = '0;
        mem_read_i = 1'b0;
        mem_write_i = 1'b0;
        address_i = '0;
        store_data_i = '0;
        button_i = '0;
        app_i = '0;
        rising_i = 1'b0;
        display_ack_i = 1'b0;

        test_name = "reset";
        repeat (3) @(negedge clk);
        assert (!d_ack_o && !i_ack_o && !display_wen_o)
            else report_failure("acknowledge or display enable high during reset");
        reset = 1'b0;
        @(negedge clk);
        assert (!d_ack_o && !i_ack_o && !display_wen_o)
            else report_failure("acknowledge or display enable high after reset");

        test_name = "ram_write";
        for (int i = 0; i < NUM_WRITES; i++) begin
            addr = random_ram_addr();
            rnd = $random(seed);
            cpu_write(addr, rnd, 0);
            used_addr.push_back(addr);
        end

        test_name = "ram_read";
        for (int i = 0; i < NUM_READS; i++) begin
            rnd = $random(seed);
            pick = rnd[15:0] % used_addr.size();
            cpu_read(used_addr[pick], ref_mem[used_addr[pick] >> 2], 0);
        end

        test_name = "ram_fetch";
        for (int i = 0; i < NUM_FETCHES; i++) begin
            rnd = $random(seed);
            pick = rnd[15:0] % used_addr.size();
            cpu_fetch(used_addr[pick]);
        end

        // Data goes first when both requests arrive together
        test_name = "read_with_fetch";
        for (int i = 0; i < 3; i++) begin
            rnd = $random(seed);
            cpu_read_and_fetch(used_addr[rnd[7:0] % used_addr.size()],
                               used_addr[rnd[23:16] % used_addr.size()]);
        end

        test_name = "keypad";
        rnd = $random(seed);
        button = rnd[4:0];
        app = rnd[9:8];
        key_press(button, app);
        cpu_read(KEYPAD_ADDR, key_word_expected(1'b1, app, button), 2);
        cpu_read(KEYPAD_ADDR, key_word_expected(1'b0, app, button), 2);
        rnd = $random(seed);
        button = rnd[4:0];
        app = rnd[9:8];
        key_press(button, app);
        // Store to the keypad leaves the flag alone
        cpu_write(KEYPAD_ADDR, $random(seed), 2);
        cpu_read(KEYPAD_ADDR, key_word_expected(1'b1, app, button), 2);
        cpu_read(KEYPAD_ADDR, key_word_expected(1'b0, app, button), 2);

        test_name = "display";
        for (int i = 0; i < 3; i++) begin
            rnd = $random(seed);
            addr = DISPLAY_BASE + addr_t'({rnd[9:0], 2'b00});
            display_write(addr, $random(seed), 1 + rnd[18:16]);
        end
        cpu_read(DISPLAY_BASE + 32'h10, UNMAPPED_WORD, 1);

        test_name = "unmapped";
        cpu_read(32'h0000_1000, UNMAPPED_WORD, 1);
        cpu_read(32'h0000_2004, UNMAPPED_WORD, 1);
        cpu_write(32'h0000_5000, $random(seed), 1);
        cpu_read(32'h0000_5000, UNMAPPED_WORD, 1);
        rnd = $random(seed);
        cpu_read({1'b1, rnd[30:2], 2'b00}, UNMAPPED_WORD, 1);

        repeat (4) @(negedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: mmio_top.f
mmio_pkg.sv
wb_pkg.sv
wb_bus_if.sv
mmio_ctrl.sv
wb_manager.sv
sram_wb.sv
keypad_reg.sv
mmio_top.sv
tb_mmio.sv
